// ==== pipe_ctrl_consts.svh ====
// Pipeline control constants: data widths, access-size codes and RISC-V mcause codes
`ifndef PIPE_CTRL_CONSTS_SVH
`define PIPE_CTRL_CONSTS_SVH

// ==============================
// Widths
// ==============================
// Data and address width
`define XLEN 32
// Access-size field width
`define MEM_SIZE_W 2

// ==============================
// Access-size codes
// ==============================
// 0 is no access, 1 is a byte access
`define MEM_SIZE_HALF 2'd2
`define MEM_SIZE_WORD 2'd3

// ==============================
// Machine trap cause codes
// ==============================
`define CAUSE_INSTR_MISALIGNED 0
`define CAUSE_ILLEGAL_INSTR    2
`define CAUSE_BREAKPOINT       3
`define CAUSE_LOAD_MISALIGNED  4
`define CAUSE_STORE_MISALIGNED 6
// Environment call from M-mode
`define CAUSE_ECALL            11

`endif

// ==== pipe_ctrl_pkg.sv ====
// Shared types for pipeline control: stage vectors, exception and stall encodings
`default_nettype none

`include "pipe_ctrl_consts.svh"

package pipe_ctrl_pkg;

  // ==============================
  // Vector types
  // ==============================
  // PC, instruction word, effective address or trap value
  typedef logic [`XLEN-1:0] xlen_t;

  // Access size of the memory op in execute
  typedef logic [`MEM_SIZE_W-1:0] mem_size_t;

  // ==============================
  // Exception types
  // ==============================
  // Carried down the pipe with each instruction
  typedef enum logic [2:0] {
    NO_EXCEPTION,
    INSTR_MISALIGNED,
    ILLEGAL_INSTRUCTION,
    BREAKPOINT,
    ECALL,
    LOAD_MISALIGNED,
    STORE_MISALIGNED
  } exc_type_e;

  // ==============================
  // Stall causes
  // ==============================
  // Ordered as listed; the arbiter applies the priority
  typedef enum logic [2:0] {
    NO_STALL,
    IMISS_STALL,
    DMISS_STALL,
    LOAD_RAW_STALL,
    ALU_STALL
  } stall_e;

endpackage

`default_nettype wire

// ==== exc_qualify.sv ====
// Exception qualifier: masks wrong-path exceptions and flags misaligned loads and stores
`timescale 1ns/1ps
`default_nettype none

`include "pipe_ctrl_consts.svh"

module exc_qualify (
  // Branch prediction confirmed in execute
  input  logic                     spec_hit_i,
  // Raw stage exceptions
  input  pipe_ctrl_pkg::exc_type_e fe_exc_i,
  input  pipe_ctrl_pkg::exc_type_e de_pipe_exc_i,
  input  pipe_ctrl_pkg::exc_type_e de_dec_exc_i,
  input  pipe_ctrl_pkg::exc_type_e ex_alu_exc_i,
  // Memory access in execute
  input  pipe_ctrl_pkg::mem_size_t ex_mem_size_i,
  input  logic                     ex_mem_wr_i,
  input  pipe_ctrl_pkg::xlen_t     ex_addr_i,
  // Qualified exceptions
  output pipe_ctrl_pkg::exc_type_e fe_exc_o,
  output pipe_ctrl_pkg::exc_type_e de_exc_o,
  output pipe_ctrl_pkg::exc_type_e ex_exc_o
);

  logic                     ex_misaligned;
  pipe_ctrl_pkg::exc_type_e de_merged;

  // ==============================
  // Fetch and decode
  // ==============================
  // Carried exception from fetch wins over the decoder's own
  assign de_merged = (de_pipe_exc_i != pipe_ctrl_pkg::NO_EXCEPTION) ? de_pipe_exc_i
                                                                   : de_dec_exc_i;

  // Wrong-path instructions never raise a trap
  assign fe_exc_o = spec_hit_i ? fe_exc_i  : pipe_ctrl_pkg::NO_EXCEPTION;
  assign de_exc_o = spec_hit_i ? de_merged : pipe_ctrl_pkg::NO_EXCEPTION;

  // ==============================
  // Execute
  // ==============================
  // Alignment check on the effective address
  always_comb begin
    case (ex_mem_size_i)
      // Halfword needs bit 0 clear
      `MEM_SIZE_HALF: ex_misaligned = ex_addr_i[0];
      // Word needs both low bits clear
      `MEM_SIZE_WORD: ex_misaligned = |ex_addr_i[1:0];
      // No access or byte access
      default:        ex_misaligned = 1'b0;
    endcase
  end

  // ALU exception first, then the memory alignment fault
  // Not masked by spec_hit since execute is the resolving stage
  always_comb begin
    if (ex_alu_exc_i != pipe_ctrl_pkg::NO_EXCEPTION) begin
      ex_exc_o = ex_alu_exc_i;
    end else if (ex_misaligned) begin
      // Write flag picks store over load
      ex_exc_o = ex_mem_wr_i ? pipe_ctrl_pkg::STORE_MISALIGNED
                             : pipe_ctrl_pkg::LOAD_MISALIGNED;
    end else begin
      ex_exc_o = pipe_ctrl_pkg::NO_EXCEPTION;
    end
  end

endmodule

`default_nettype wire

// ==== trap_arbiter.sv ====
// Trap arbiter: stall priority, flush decisions and selection of trap cause, mepc and tval
`timescale 1ns/1ps
`default_nettype none

`include "pipe_ctrl_consts.svh"

module trap_arbiter (
  // Stall requests
  input  logic                     imiss_stall_i,
  input  logic                     dmiss_stall_i,
  input  logic                     raw_stall_i,
  input  logic                     alu_stall_i,
  // Hazard unit flushes
  input  logic                     hz_de_flush_i,
  input  logic                     hz_ex_flush_i,
  // Qualified exceptions
  input  pipe_ctrl_pkg::exc_type_e fe_exc_i,
  input  pipe_ctrl_pkg::exc_type_e de_exc_i,
  input  pipe_ctrl_pkg::exc_type_e ex_exc_i,
  // Stage values
  input  pipe_ctrl_pkg::xlen_t     fe_pc_i,
  input  pipe_ctrl_pkg::xlen_t     fe_inst_i,
  input  pipe_ctrl_pkg::xlen_t     de_pc_i,
  input  pipe_ctrl_pkg::xlen_t     de_inst_i,
  input  pipe_ctrl_pkg::xlen_t     ex_pc_i,
  input  pipe_ctrl_pkg::xlen_t     ex_inst_i,
  input  pipe_ctrl_pkg::xlen_t     ex_addr_i,
  // Pipeline control
  output pipe_ctrl_pkg::stall_e    stall_cause_o,
  output logic                     de_enable_o,
  output logic                     de_flush_o,
  output logic                     ex_flush_o,
  output logic                     me_flush_o,
  // Trap request
  output logic                     trap_take_o,
  output pipe_ctrl_pkg::xlen_t     cause_o,
  output pipe_ctrl_pkg::xlen_t     mepc_o,
  output pipe_ctrl_pkg::xlen_t     tval_o
);

  logic                     hard_stall;
  logic                     fe_has_exc;
  logic                     de_has_exc;
  logic                     ex_has_exc;
  logic                     win_from_ex;
  pipe_ctrl_pkg::exc_type_e win_exc;
  pipe_ctrl_pkg::xlen_t     win_pc;
  pipe_ctrl_pkg::xlen_t     win_inst;

  // Exception type to mcause code
  function automatic pipe_ctrl_pkg::xlen_t cause_code(input pipe_ctrl_pkg::exc_type_e exc);
    pipe_ctrl_pkg::xlen_t code;
    case (exc)
      pipe_ctrl_pkg::INSTR_MISALIGNED:    code = pipe_ctrl_pkg::xlen_t'(`CAUSE_INSTR_MISALIGNED);
      pipe_ctrl_pkg::ILLEGAL_INSTRUCTION: code = pipe_ctrl_pkg::xlen_t'(`CAUSE_ILLEGAL_INSTR);
      pipe_ctrl_pkg::BREAKPOINT:          code = pipe_ctrl_pkg::xlen_t'(`CAUSE_BREAKPOINT);
      pipe_ctrl_pkg::ECALL:               code = pipe_ctrl_pkg::xlen_t'(`CAUSE_ECALL);
      pipe_ctrl_pkg::LOAD_MISALIGNED:     code = pipe_ctrl_pkg::xlen_t'(`CAUSE_LOAD_MISALIGNED);
      pipe_ctrl_pkg::STORE_MISALIGNED:    code = pipe_ctrl_pkg::xlen_t'(`CAUSE_STORE_MISALIGNED);
      default:                            code = '0;
    endcase
    return code;
  endfunction

  // ==============================
  // Stall priority
  // ==============================
  // imiss > dmiss > load RAW > ALU
  always_comb begin
    if (imiss_stall_i) begin
      stall_cause_o = pipe_ctrl_pkg::IMISS_STALL;
    end else if (dmiss_stall_i) begin
      stall_cause_o = pipe_ctrl_pkg::DMISS_STALL;
    end else if (raw_stall_i) begin
      stall_cause_o = pipe_ctrl_pkg::LOAD_RAW_STALL;
    end else if (alu_stall_i) begin
      stall_cause_o = pipe_ctrl_pkg::ALU_STALL;
    end else begin
      stall_cause_o = pipe_ctrl_pkg::NO_STALL;
    end
  end

  // Decode advances only with no stall at all
  assign de_enable_o = (stall_cause_o == pipe_ctrl_pkg::NO_STALL);

  // A load RAW stall still lets hazard flushes through
  assign hard_stall = stall_cause_o inside {pipe_ctrl_pkg::IMISS_STALL,
                                            pipe_ctrl_pkg::DMISS_STALL,
                                            pipe_ctrl_pkg::ALU_STALL};

  // ==============================
  // Flush decisions
  // ==============================
  assign fe_has_exc = (fe_exc_i != pipe_ctrl_pkg::NO_EXCEPTION);
  assign de_has_exc = (de_exc_i != pipe_ctrl_pkg::NO_EXCEPTION);
  assign ex_has_exc = (ex_exc_i != pipe_ctrl_pkg::NO_EXCEPTION);

  // Younger stages are squashed behind a faulting instruction
  assign de_flush_o = (hz_de_flush_i && !hard_stall) || ex_has_exc || de_has_exc;
  assign ex_flush_o = (hz_ex_flush_i && !hard_stall) || ex_has_exc || de_has_exc;
  // Only an execute fault kills the op entering memory
  assign me_flush_o = ex_has_exc;

  // ==============================
  // Trap selection
  // ==============================
  assign trap_take_o = ex_has_exc || de_has_exc || fe_has_exc;

  // Oldest stage wins: execute, then decode, then fetch
  always_comb begin
    win_from_ex = 1'b0;
    win_exc     = pipe_ctrl_pkg::NO_EXCEPTION;
    win_pc      = '0;
    win_inst    = '0;
    if (ex_has_exc) begin
      win_from_ex = 1'b1;
      win_exc     = ex_exc_i;
      win_pc      = ex_pc_i;
      win_inst    = ex_inst_i;
    end else if (de_has_exc) begin
      win_exc  = de_exc_i;
      win_pc   = de_pc_i;
      win_inst = de_inst_i;
    end else if (fe_has_exc) begin
      win_exc  = fe_exc_i;
      win_pc   = fe_pc_i;
      win_inst = fe_inst_i;
    end
  end

  assign cause_o = cause_code(win_exc);
  assign mepc_o  = win_pc;

  // Trap value by exception type
  always_comb begin
    case (win_exc)
      pipe_ctrl_pkg::ILLEGAL_INSTRUCTION: tval_o = win_inst;
      // Faulting effective address
      pipe_ctrl_pkg::LOAD_MISALIGNED,
      pipe_ctrl_pkg::STORE_MISALIGNED:    tval_o = ex_addr_i;
      // Target PC only known for fetch and decode faults
      pipe_ctrl_pkg::INSTR_MISALIGNED:    tval_o = win_from_ex ? '0 : win_pc;
      default:                            tval_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== trap_capture.sv ====
// Trap capture: machine trap registers loaded on a taken trap, with a one-cycle valid pulse
`timescale 1ns/1ps
`default_nettype none

module trap_capture (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Trap request from the arbiter
  input  logic                 trap_take_i,
  input  pipe_ctrl_pkg::xlen_t cause_i,
  input  pipe_ctrl_pkg::xlen_t mepc_i,
  input  pipe_ctrl_pkg::xlen_t tval_i,
  // Captured trap state
  output logic                 trap_valid_o,
  output pipe_ctrl_pkg::xlen_t mcause_o,
  output pipe_ctrl_pkg::xlen_t mepc_o,
  output pipe_ctrl_pkg::xlen_t mtval_o
);

  logic                 valid_q;
  pipe_ctrl_pkg::xlen_t mcause_q;
  pipe_ctrl_pkg::xlen_t mepc_q;
  pipe_ctrl_pkg::xlen_t mtval_q;

  // ==============================
  // Capture registers
  // ==============================
  // Stalls do not hold off a capture
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      mcause_q <= '0;
      mepc_q   <= '0;
      mtval_q  <= '0;
    end else begin
      // One pulse per taken trap
      valid_q <= trap_take_i;
      // Values hold until the next trap
      if (trap_take_i) begin
        mcause_q <= cause_i;
        mepc_q   <= mepc_i;
        mtval_q  <= tval_i;
      end
    end
  end

  assign trap_valid_o = valid_q;
  assign mcause_o     = mcause_q;
  assign mepc_o       = mepc_q;
  assign mtval_o      = mtval_q;

endmodule

`default_nettype wire

// ==== pipe_ctrl.sv ====
// Pipeline control top: exception qualification, stall and trap arbitration, trap capture
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Branch prediction result
  input  logic                     spec_hit_i,
  // Raw stage exceptions
  input  pipe_ctrl_pkg::exc_type_e fe_exc_i,
  input  pipe_ctrl_pkg::exc_type_e de_pipe_exc_i,
  input  pipe_ctrl_pkg::exc_type_e de_dec_exc_i,
  input  pipe_ctrl_pkg::exc_type_e ex_alu_exc_i,
  // Execute memory access
  input  pipe_ctrl_pkg::mem_size_t ex_mem_size_i,
  input  logic                     ex_mem_wr_i,
  input  pipe_ctrl_pkg::xlen_t     ex_addr_i,
  // Stall requests
  input  logic                     imiss_stall_i,
  input  logic                     dmiss_stall_i,
  input  logic                     raw_stall_i,
  input  logic                     alu_stall_i,
  // Hazard flushes
  input  logic                     hz_de_flush_i,
  input  logic                     hz_ex_flush_i,
  // Stage PCs and instruction words
  input  pipe_ctrl_pkg::xlen_t     fe_pc_i,
  input  pipe_ctrl_pkg::xlen_t     fe_inst_i,
  input  pipe_ctrl_pkg::xlen_t     de_pc_i,
  input  pipe_ctrl_pkg::xlen_t     de_inst_i,
  input  pipe_ctrl_pkg::xlen_t     ex_pc_i,
  input  pipe_ctrl_pkg::xlen_t     ex_inst_i,
  // Pipeline control outputs
  output pipe_ctrl_pkg::stall_e    stall_cause_o,
  output logic                     de_enable_o,
  output logic                     de_flush_o,
  output logic                     ex_flush_o,
  output logic                     me_flush_o,
  // Captured trap
  output logic                     trap_valid_o,
  output pipe_ctrl_pkg::xlen_t     mcause_o,
  output pipe_ctrl_pkg::xlen_t     mepc_o,
  output pipe_ctrl_pkg::xlen_t     mtval_o
);

  // Qualified exceptions
  pipe_ctrl_pkg::exc_type_e fe_exc_q;
  pipe_ctrl_pkg::exc_type_e de_exc_q;
  pipe_ctrl_pkg::exc_type_e ex_exc_q;
  // Trap request into capture
  logic                     trap_take;
  pipe_ctrl_pkg::xlen_t     trap_cause;
  pipe_ctrl_pkg::xlen_t     trap_mepc;
  pipe_ctrl_pkg::xlen_t     trap_tval;

  // ==============================
  // Input side
  // ==============================
  exc_qualify u_exc_qualify (
    .spec_hit_i   (spec_hit_i),
    .fe_exc_i     (fe_exc_i),
    .de_pipe_exc_i(de_pipe_exc_i),
    .de_dec_exc_i (de_dec_exc_i),
    .ex_alu_exc_i (ex_alu_exc_i),
    .ex_mem_size_i(ex_mem_size_i),
    .ex_mem_wr_i  (ex_mem_wr_i),
    .ex_addr_i    (ex_addr_i),
    .fe_exc_o     (fe_exc_q),
    .de_exc_o     (de_exc_q),
    .ex_exc_o     (ex_exc_q)
  );

  // ==============================
  // Arbitration
  // ==============================
  trap_arbiter u_trap_arbiter (
    .imiss_stall_i(imiss_stall_i),
    .dmiss_stall_i(dmiss_stall_i),
    .raw_stall_i  (raw_stall_i),
    .alu_stall_i  (alu_stall_i),
    .hz_de_flush_i(hz_de_flush_i),
    .hz_ex_flush_i(hz_ex_flush_i),
    .fe_exc_i     (fe_exc_q),
    .de_exc_i     (de_exc_q),
    .ex_exc_i     (ex_exc_q),
    .fe_pc_i      (fe_pc_i),
    .fe_inst_i    (fe_inst_i),
    .de_pc_i      (de_pc_i),
    .de_inst_i    (de_inst_i),
    .ex_pc_i      (ex_pc_i),
    .ex_inst_i    (ex_inst_i),
    .ex_addr_i    (ex_addr_i),
    .stall_cause_o(stall_cause_o),
    .de_enable_o  (de_enable_o),
    .de_flush_o   (de_flush_o),
    .ex_flush_o   (ex_flush_o),
    .me_flush_o   (me_flush_o),
    .trap_take_o  (trap_take),
    .cause_o      (trap_cause),
    .mepc_o       (trap_mepc),
    .tval_o       (trap_tval)
  );

  // ==============================
  // Output side
  // ==============================
  trap_capture u_trap_capture (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .trap_take_i (trap_take),
    .cause_i     (trap_cause),
    .mepc_i      (trap_mepc),
    .tval_i      (trap_tval),
    .trap_valid_o(trap_valid_o),
    .mcause_o    (mcause_o),
    .mepc_o      (mepc_o),
    .mtval_o     (mtval_o)
  );

endmodule

`default_nettype wire

// ==== tb_pipe_ctrl.sv ====
// Testbench for the pipeline control block, driven by vectors from a text file
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ctrl;

  localparam int HALF_PERIOD   = 50;
  localparam int RESET_CYCLES  = 10;
  // Bounds on the reset wait and on the vector file walk
  localparam int RESET_TIMEOUT = 50;
  localparam int MAX_LINES     = 1000;

  // ==============================
  // DUT signals
  // ==============================
  logic                     clk;
  logic                     rst_n;
  logic                     spec_hit;
  pipe_ctrl_pkg::exc_type_e fe_exc;
  pipe_ctrl_pkg::exc_type_e de_pipe_exc;
  pipe_ctrl_pkg::exc_type_e de_dec_exc;
  pipe_ctrl_pkg::exc_type_e ex_alu_exc;
  pipe_ctrl_pkg::mem_size_t ex_mem_size;
  logic                     ex_mem_wr;
  pipe_ctrl_pkg::xlen_t     ex_addr;
  logic                     imiss_stall;
  logic                     dmiss_stall;
  logic                     raw_stall;
  logic                     alu_stall;
  logic                     hz_de_flush;
  logic                     hz_ex_flush;
  pipe_ctrl_pkg::xlen_t     stage_val [6];
  pipe_ctrl_pkg::stall_e    stall_cause;
  logic                     de_enable;
  logic                     de_flush;
  logic                     ex_flush;
  logic                     me_flush;
  logic                     trap_valid;
  pipe_ctrl_pkg::xlen_t     mcause;
  pipe_ctrl_pkg::xlen_t     mepc;
  pipe_ctrl_pkg::xlen_t     mtval;

  // Current vector
  string       v_name;
  logic        v_spec;
  logic [2:0]  v_exc [4];     // fe, de pipe, de decoder, ex ALU
  logic [1:0]  v_size;
  logic        v_wr;
  logic [31:0] v_addr;
  logic [3:0]  v_stall;       // imiss, dmiss, raw, alu
  logic [1:0]  v_hz;          // de, ex
  logic [31:0] v_stage [6];   // fe pc/inst, de pc/inst, ex pc/inst
  logic [2:0]  e_stall;
  logic [3:0]  e_flags;       // enable, de/ex/me flush
  logic        e_valid;
  logic [31:0] e_trap [3];    // mcause, mepc, mtval
  // Previous vector whose capture shows up one edge later
  string       p_name;
  logic        p_valid;
  logic [31:0] p_trap [3];
  bit          p_pending;
  int          p_start_err;
  // Run status
  int          error_count;
  int          tests_run;
  int          tests_failed;
  bit          aborted;

  pipe_ctrl i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .spec_hit_i   (spec_hit),
    .fe_exc_i     (fe_exc),
    .de_pipe_exc_i(de_pipe_exc),
    .de_dec_exc_i (de_dec_exc),
    .ex_alu_exc_i (ex_alu_exc),
    .ex_mem_size_i(ex_mem_size),
    .ex_mem_wr_i  (ex_mem_wr),
    .ex_addr_i    (ex_addr),
    .imiss_stall_i(imiss_stall),
    .dmiss_stall_i(dmiss_stall),
    .raw_stall_i  (raw_stall),
    .alu_stall_i  (alu_stall),
    .hz_de_flush_i(hz_de_flush),
    .hz_ex_flush_i(hz_ex_flush),
    .fe_pc_i      (stage_val[0]),
    .fe_inst_i    (stage_val[1]),
    .de_pc_i      (stage_val[2]),
    .de_inst_i    (stage_val[3]),
    .ex_pc_i      (stage_val[4]),
    .ex_inst_i    (stage_val[5]),
    .stall_cause_o(stall_cause),
    .de_enable_o  (de_enable),
    .de_flush_o   (de_flush),
    .ex_flush_o   (ex_flush),
    .me_flush_o   (me_flush),
    .trap_valid_o (trap_valid),
    .mcause_o     (mcause),
    .mepc_o       (mepc),
    .mtval_o      (mtval)
  );

  // ==============================
  // Clock and reset
  // ==============================
  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  initial begin
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

  // ==============================
  // Checks and reporting
  // ==============================
  task automatic check_value(input string test, input string field,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      error_count++;
      $display("** Error %s: %s expected 0x%0h, got 0x%0h", test, field, exp_v, act_v);
    end
  endtask

  // One result line per finished test
  task automatic end_test(input string name, input int start_err);
    tests_run++;
    if (error_count != start_err) begin
      tests_failed++;
      $display("FAIL  %s", name);
    end else begin
      $display("PASS  %s", name);
    end
  endtask

  task automatic check_reset_state();
    int start;
    start = error_count;
    check_value("reset", "trap_valid_o", 32'd0, 32'(trap_valid));
    check_value("reset", "mcause_o", 32'd0, mcause);
    check_value("reset", "mepc_o", 32'd0, mepc);
    check_value("reset", "mtval_o", 32'd0, mtval);
    end_test("reset", start);
  endtask

  // Same-cycle outputs of the current vector
  task automatic check_comb();
    check_value(v_name, "stall_cause_o", 32'(e_stall), 32'(stall_cause));
    check_value(v_name, "de_enable_o", 32'(e_flags[3]), 32'(de_enable));
    check_value(v_name, "de_flush_o", 32'(e_flags[2]), 32'(de_flush));
    check_value(v_name, "ex_flush_o", 32'(e_flags[1]), 32'(ex_flush));
    check_value(v_name, "me_flush_o", 32'(e_flags[0]), 32'(me_flush));
  endtask

  // Trap registers one edge after the previous vector
  task automatic check_capture();
    check_value(p_name, "trap_valid_o", 32'(p_valid), 32'(trap_valid));
    check_value(p_name, "mcause_o", p_trap[0], mcause);
    check_value(p_name, "mepc_o", p_trap[1], mepc);
    check_value(p_name, "mtval_o", p_trap[2], mtval);
    end_test(p_name, p_start_err);
    p_pending = 1'b0;
  endtask

  // ==============================
  // Stimulus
  // ==============================
  task automatic clear_inputs();
    spec_hit    <= 1'b1;
    fe_exc      <= pipe_ctrl_pkg::NO_EXCEPTION;
    de_pipe_exc <= pipe_ctrl_pkg::NO_EXCEPTION;
    de_dec_exc  <= pipe_ctrl_pkg::NO_EXCEPTION;
    ex_alu_exc  <= pipe_ctrl_pkg::NO_EXCEPTION;
    ex_mem_size <= '0;
    ex_mem_wr   <= 1'b0;
    ex_addr     <= '0;
    {imiss_stall, dmiss_stall, raw_stall, alu_stall} <= 4'b0000;
    {hz_de_flush, hz_ex_flush} <= 2'b00;
    for (int i = 0; i < 6; i++) begin
      stage_val[i] <= '0;
    end
  endtask

  task automatic drive_vector();
    spec_hit    <= v_spec;
    fe_exc      <= pipe_ctrl_pkg::exc_type_e'(v_exc[0]);
    de_pipe_exc <= pipe_ctrl_pkg::exc_type_e'(v_exc[1]);
    de_dec_exc  <= pipe_ctrl_pkg::exc_type_e'(v_exc[2]);
    ex_alu_exc  <= pipe_ctrl_pkg::exc_type_e'(v_exc[3]);
    ex_mem_size <= v_size;
    ex_mem_wr   <= v_wr;
    ex_addr     <= v_addr;
    {imiss_stall, dmiss_stall, raw_stall, alu_stall} <= v_stall;
    {hz_de_flush, hz_ex_flush} <= v_hz;
    for (int i = 0; i < 6; i++) begin
      stage_val[i] <= v_stage[i];
    end
  endtask

  function automatic bit is_vector_line(input string s);
    return s.len() > 0 && s[0] != "#" && s[0] != "\n" && s[0] != "\r";
  endfunction

  task automatic wait_reset(output bit released);
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    released = (rst_n === 1'b1);
  endtask

  // Walk the vector file to its end within MAX_LINES lines
  task automatic run_vectors();
    int    fd;
    int    fields;
    int    line_no;
    bit    at_end;
    string line;
    fd = $fopen("pipe_ctrl_input.txt", "r");
    if (fd == 0) begin
      $display("The vector file pipe_ctrl_input.txt could not be opened");
      aborted = 1'b1;
    end else begin
      line_no = 0;
      at_end  = 1'b0;
      while (!at_end && line_no < MAX_LINES) begin
        line_no++;
        if ($fgets(line, fd) == 0) begin
          at_end = 1'b1;
        end else if (is_vector_line(line)) begin
          fields = $sscanf(line,
            "%s %d %d %d %d %d %d %d %h %b %b %h %h %h %h %h %h %d %b %d %d %h %h",
            v_name, v_spec, v_exc[0], v_exc[1], v_exc[2], v_exc[3], v_size, v_wr,
            v_addr, v_stall, v_hz, v_stage[0], v_stage[1], v_stage[2], v_stage[3],
            v_stage[4], v_stage[5], e_stall, e_flags, e_valid, e_trap[0], e_trap[1],
            e_trap[2]);
          if (fields != 23) begin
            $display("Line %0d of the vector file could not be parsed", line_no);
            aborted = 1'b1;
          end else begin
            @(posedge clk);
            drive_vector();
            if (p_pending) begin
              #1;
              check_capture();
            end
            @(negedge clk);
            p_start_err = error_count;
            check_comb();
            p_name    = v_name;
            p_valid   = e_valid;
            p_trap    = e_trap;
            p_pending = 1'b1;
          end
        end
      end
      if (!at_end) begin
        $display("The vector file did not end within %0d lines", MAX_LINES);
        aborted = 1'b1;
      end
      $fclose(fd);
      // Last capture
      if (p_pending) begin
        @(posedge clk);
        #1;
        check_capture();
      end
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d run, %0d passed, %0d failed, %0d mismatches",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (!aborted && error_count == 0 && tests_run > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    bit released;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    p_pending    = 1'b0;
    clear_inputs();
    // Trap request on the first reset edge must not reach the trap registers
    ex_alu_exc   <= pipe_ctrl_pkg::ILLEGAL_INSTRUCTION;
    stage_val[4] <= 32'h0000_0200;
    stage_val[5] <= 32'hffff_ffff;
    @(posedge clk);
    clear_inputs();
    wait_reset(released);
    if (!released) begin
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
      aborted = 1'b1;
    end else begin
      @(negedge clk);
      check_reset_state();
      run_vectors();
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== pipe_ctrl_input.txt ====
# name spec exc(fe dp dd ea) size wr addr stall(im,dm,raw,alu) hz(de,ex) fpc finst dpc dinst epc einst
# expected: stall flags(en,dfl,xfl,mfl) valid mcause(dec) mepc mtval, trap values after the next edge
stall_none 1 0 0 0 0 0 0 0 0000 00 108 13 104 13 100 13 0 1000 0 0 0 0
stall_all 1 0 0 0 0 0 0 0 1111 00 108 13 104 13 100 13 1 0000 0 0 0 0
stall_dm_raw_alu 1 0 0 0 0 0 0 0 0111 00 108 13 104 13 100 13 2 0000 0 0 0 0
stall_raw_alu 1 0 0 0 0 0 0 0 0011 00 108 13 104 13 100 13 3 0000 0 0 0 0
stall_alu 1 0 0 0 0 0 0 0 0001 00 108 13 104 13 100 13 4 0000 0 0 0 0
stall_im_alu 1 0 0 0 0 0 0 0 1001 00 108 13 104 13 100 13 1 0000 0 0 0 0
flush_free 1 0 0 0 0 0 0 0 0000 11 108 13 104 13 100 13 0 1110 0 0 0 0
flush_raw 1 0 0 0 0 0 0 0 0010 11 108 13 104 13 100 13 3 0110 0 0 0 0
flush_imiss 1 0 0 0 0 0 0 0 1000 11 108 13 104 13 100 13 1 0000 0 0 0 0
flush_dmiss 1 0 0 0 0 0 0 0 0100 11 108 13 104 13 100 13 2 0000 0 0 0 0
flush_alu 1 0 0 0 0 0 0 0 0001 11 108 13 104 13 100 13 4 0000 0 0 0 0
flush_de_only 1 0 0 0 0 0 0 0 0000 10 108 13 104 13 100 13 0 1100 0 0 0 0
flush_ex_raw 1 0 0 0 0 0 0 0 0010 01 108 13 104 13 100 13 3 0010 0 0 0 0
ld_half_even 1 0 0 0 0 2 0 2002 0000 00 108 13 104 13 100 13 0 1000 0 0 0 0
ld_half_odd 1 0 0 0 0 2 0 2001 0000 00 108 13 104 13 100 13 0 1111 1 4 100 2001
st_half_odd 1 0 0 0 0 2 1 2003 0000 00 108 13 104 13 100 13 0 1111 1 6 100 2003
ld_word_b1 1 0 0 0 0 3 0 2002 0000 00 108 13 104 13 100 13 0 1111 1 4 100 2002
st_word_b0 1 0 0 0 0 3 1 2001 0000 00 108 13 104 13 100 13 0 1111 1 6 100 2001
st_word_b01 1 0 0 0 0 3 1 2003 0000 00 108 13 104 13 100 13 0 1111 1 6 100 2003
ld_word_align 1 0 0 0 0 3 0 2004 0000 00 108 13 104 13 100 13 0 1000 0 6 100 2003
st_half_align 1 0 0 0 0 2 1 2006 0000 00 108 13 104 13 100 13 0 1000 0 6 100 2003
ld_byte_odd 1 0 0 0 0 1 0 2001 0000 00 108 13 104 13 100 13 0 1000 0 6 100 2003
ld_half_dmiss 1 0 0 0 0 2 0 2005 0100 00 108 13 104 13 100 13 2 0111 1 4 100 2005
spec_fe_miss 0 1 0 0 0 0 0 0 0000 00 10a 13 104 13 100 13 0 1000 0 4 100 2005
spec_dd_miss 0 0 0 2 0 0 0 0 0000 00 108 13 104 dead 100 13 0 1000 0 4 100 2005
spec_dp_miss 0 0 3 0 0 0 0 0 0000 00 108 13 104 13 100 13 0 1000 0 4 100 2005
spec_fe_hit 1 1 0 0 0 0 0 0 0000 00 10a 13 104 13 100 13 0 1000 1 0 10a 10a
spec_dd_hit 1 0 0 2 0 0 0 0 0000 00 108 13 104 dead 100 13 0 1110 1 2 104 dead
spec_ex_kept 0 0 0 0 4 0 0 0 0000 00 108 13 104 13 100 13 0 1111 1 11 100 0
pri_ex_de_fe 1 2 0 4 2 0 0 0 0000 00 108 bad3 104 13 100 bad1 0 1111 1 2 100 bad1
pri_de_fe 1 2 1 0 0 0 0 0 0000 00 108 bad3 106 13 100 13 0 1110 1 0 106 106
pri_pipe_dec 1 0 4 2 0 0 0 0 0000 00 108 13 104 bad2 100 13 0 1110 1 11 104 0
pri_ex_imis 1 0 0 2 1 0 0 0 0000 00 108 13 104 13 102 13 0 1111 1 0 102 0
pri_mis_de 1 0 0 3 0 3 1 3002 0000 00 108 13 104 13 100 13 0 1111 1 6 100 3002
pri_fe_ecall 1 4 0 0 0 0 0 0 0000 00 108 13 104 13 100 13 0 1000 1 11 108 0
pri_alu_mis 1 0 0 0 3 2 0 2001 0000 00 108 13 104 13 100 13 0 1111 1 3 100 0
exc_imiss 1 0 0 2 0 0 0 0 1000 00 108 13 104 beef 100 13 1 0110 1 2 104 beef
hold_idle 1 0 0 0 0 0 0 0 0000 00 108 13 104 13 100 13 0 1000 0 2 104 beef
hold_masked 0 2 0 0 0 0 0 0 1111 11 108 13 104 13 100 13 1 0000 0 2 104 beef
hold_raw_flush 1 0 0 0 0 0 0 0 0010 11 108 13 104 13 100 13 3 0110 0 2 104 beef

// ==== verilog.f ====
+incdir+.
pipe_ctrl_pkg.sv
exc_qualify.sv
trap_arbiter.sv
trap_capture.sv
pipe_ctrl.sv
tb_pipe_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pipeline control testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f verilog.f --top-module tb_pipe_ctrl -o tb_pipe_ctrl
./obj_dir/tb_pipe_ctrl | tee sim.log
if grep -q "tests failed" sim.log; then
  echo "Simulation result: FAIL"
  exit 1
fi
echo "Simulation result: PASS"
